// File: design/core_mem_params.svh
`ifndef CORE_MEM_PARAMS_SVH
`define CORE_MEM_PARAMS_SVH

// bus widths
`define CMR_ADDR_WIDTH      32
`define CMR_DATA_WIDTH      32
`define CMR_BE_WIDTH        4

// local data RAM, 1024 words
`define CMR_RAM_WORD_BITS   10

// region decode on the upper address bits
`define CMR_REGION_MSB_BITS 12
`define CMR_LOCAL_REGION    12'h001

`endif

// File: design/core_mem_pkg.sv
`include "core_mem_params.svh"

package core_mem_pkg;

  // byte address
  typedef logic [`CMR_ADDR_WIDTH-1:0]    addr_t;

  // data word and its byte enables
  typedef logic [`CMR_DATA_WIDTH-1:0]    data_t;
  typedef logic [`CMR_BE_WIDTH-1:0]      be_t;

  // word index into the local RAM, byte address bits 11:2
  typedef logic [`CMR_RAM_WORD_BITS-1:0] ram_addr_t;

  // who owes the next load/store response
  typedef enum logic [0:0]
  {
    RESP_BUS = 1'b0,
    RESP_RAM = 1'b1
  } resp_src_e;

endpackage

// File: design/sp_ram.sv
`include "core_mem_params.svh"

module sp_ram
(
  input  logic                  clk,

  input  logic                  en_i,
  input  core_mem_pkg::ram_addr_t addr_i,
  input  logic                  we_i,
  input  core_mem_pkg::be_t     be_i,
  input  core_mem_pkg::data_t   wdata_i,
  output core_mem_pkg::data_t   rdata_o
);

  localparam int NUM_WORDS = 1 << `CMR_RAM_WORD_BITS;

  core_mem_pkg::data_t mem [0:NUM_WORDS-1];

  // one access per cycle, read data lands on the next edge
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < `CMR_BE_WIDTH; i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: design/ram_arbiter.sv
`include "core_mem_params.svh"

module ram_arbiter
(
  input  logic                    clk,
  input  logic                    rst_n,

  // loader port, highest priority
  input  logic                    ld_req_i,
  input  core_mem_pkg::addr_t     ld_addr_i,
  input  logic                    ld_we_i,
  input  core_mem_pkg::be_t       ld_be_i,
  input  core_mem_pkg::data_t     ld_wdata_i,
  output logic                    ld_gnt_o,
  output logic                    ld_rvalid_o,
  output core_mem_pkg::data_t     ld_rdata_o,

  // load/store port
  input  logic                    lsu_req_i,
  input  core_mem_pkg::addr_t     lsu_addr_i,
  input  logic                    lsu_we_i,
  input  core_mem_pkg::be_t       lsu_be_i,
  input  core_mem_pkg::data_t     lsu_wdata_i,
  output logic                    lsu_gnt_o,
  output logic                    lsu_rvalid_o,
  output core_mem_pkg::data_t     lsu_rdata_o,

  // single RAM port
  output logic                    mem_en_o,
  output core_mem_pkg::ram_addr_t mem_addr_o,
  output logic                    mem_we_o,
  output core_mem_pkg::be_t       mem_be_o,
  output core_mem_pkg::data_t     mem_wdata_o,
  input  core_mem_pkg::data_t     mem_rdata_i
);

  core_mem_pkg::addr_t sel_addr;
  logic                rvalid_q;
  logic                ld_owner_q;

  // loader always wins, lsu only gets the free cycles
  assign ld_gnt_o  = ld_req_i;
  assign lsu_gnt_o = lsu_req_i & ~ld_req_i;

  assign mem_en_o = ld_req_i | lsu_req_i;

  always_comb
  begin
    if (ld_req_i)
    begin
      sel_addr    = ld_addr_i;
      mem_we_o    = ld_we_i;
      mem_be_o    = ld_be_i;
      mem_wdata_o = ld_wdata_i;
    end
    else
    begin
      sel_addr    = lsu_addr_i;
      mem_we_o    = lsu_we_i;
      mem_be_o    = lsu_be_i;
      mem_wdata_o = lsu_wdata_i;
    end
  end

  // byte address to word index
  assign mem_addr_o = sel_addr[`CMR_RAM_WORD_BITS+1:2];

  // remember the owner of the access now in the RAM read stage
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid_q   <= 1'b0;
      ld_owner_q <= 1'b0;
    end
    else
    begin
      rvalid_q   <= mem_en_o;
      ld_owner_q <= ld_req_i;
    end
  end

  assign ld_rvalid_o  = rvalid_q & ld_owner_q;
  assign lsu_rvalid_o = rvalid_q & ~ld_owner_q;

  // both ports see the RAM word, only the owner gets rvalid
  assign ld_rdata_o  = mem_rdata_i;
  assign lsu_rdata_o = mem_rdata_i;

endmodule

// File: design/lsu_demux.sv
`include "core_mem_params.svh"

module lsu_demux
(
  input  logic                clk,
  input  logic                rst_n,

  // from the load/store unit
  input  logic                lsu_req_i,
  input  core_mem_pkg::addr_t lsu_addr_i,
  input  logic                lsu_we_i,
  input  core_mem_pkg::be_t   lsu_be_i,
  input  core_mem_pkg::data_t lsu_wdata_i,
  output logic                lsu_gnt_o,
  output logic                lsu_rvalid_o,
  output core_mem_pkg::data_t lsu_rdata_o,

  // external bus
  output logic                bus_req_o,
  output core_mem_pkg::addr_t bus_addr_o,
  output logic                bus_we_o,
  output core_mem_pkg::be_t   bus_be_o,
  output core_mem_pkg::data_t bus_wdata_o,
  input  logic                bus_gnt_i,
  input  logic                bus_rvalid_i,
  input  core_mem_pkg::data_t bus_rdata_i,

  // local RAM side
  output logic                ram_req_o,
  output core_mem_pkg::addr_t ram_addr_o,
  output logic                ram_we_o,
  output core_mem_pkg::be_t   ram_be_o,
  output core_mem_pkg::data_t ram_wdata_o,
  input  logic                ram_gnt_i,
  input  logic                ram_rvalid_i,
  input  core_mem_pkg::data_t ram_rdata_i
);

  localparam int CNT_W = 3;

  logic                    is_local;
  core_mem_pkg::resp_src_e target;
  core_mem_pkg::resp_src_e resp_src_q;
  logic [CNT_W-1:0]        outstanding_q;
  logic                    block;
  logic                    accept;
  logic                    resp;

  assign is_local = (lsu_addr_i[`CMR_ADDR_WIDTH-1 -: `CMR_REGION_MSB_BITS]
                     == `CMR_LOCAL_REGION);
  assign target   = is_local ? core_mem_pkg::RESP_RAM : core_mem_pkg::RESP_BUS;

  // hold off a switch of target until the other side has drained
  assign block = ((outstanding_q != '0) && (target != resp_src_q))
                 || (outstanding_q == {CNT_W{1'b1}});

  assign ram_req_o = lsu_req_i & is_local & ~block;
  assign bus_req_o = lsu_req_i & ~is_local & ~block;

  assign ram_addr_o  = lsu_addr_i;
  assign ram_we_o    = lsu_we_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign bus_addr_o  = lsu_addr_i;
  assign bus_we_o    = lsu_we_i;
  assign bus_be_o    = lsu_be_i;
  assign bus_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = is_local ? (ram_req_o & ram_gnt_i) : (bus_req_o & bus_gnt_i);
  assign accept    = lsu_req_i & lsu_gnt_o;

  // route the response from whichever side owes it
  always_comb
  begin
    if (resp_src_q == core_mem_pkg::RESP_RAM)
    begin
      resp        = ram_rvalid_i;
      lsu_rdata_o = ram_rdata_i;
    end
    else
    begin
      resp        = bus_rvalid_i;
      lsu_rdata_o = bus_rdata_i;
    end
  end

  assign lsu_rvalid_o = resp;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      resp_src_q    <= core_mem_pkg::RESP_RAM;
      outstanding_q <= '0;
    end
    else
    begin
      if (accept)
      begin
        resp_src_q <= target;
      end
      if (accept && !resp)
      begin
        outstanding_q <= outstanding_q + 1'b1;
      end
      else if (!accept && resp)
      begin
        outstanding_q <= outstanding_q - 1'b1;
      end
    end
  end

endmodule

// File: design/core_mem_region.sv
`include "core_mem_params.svh"

module core_mem_region
(
  input  logic                clk,
  input  logic                rst_n,

  // load/store unit of the core
  input  logic                lsu_req_i,
  input  core_mem_pkg::addr_t lsu_addr_i,
  input  logic                lsu_we_i,
  input  core_mem_pkg::be_t   lsu_be_i,
  input  core_mem_pkg::data_t lsu_wdata_i,
  output logic                lsu_gnt_o,
  output logic                lsu_rvalid_o,
  output core_mem_pkg::data_t lsu_rdata_o,

  // external loader
  input  logic                ld_req_i,
  input  core_mem_pkg::addr_t ld_addr_i,
  input  logic                ld_we_i,
  input  core_mem_pkg::be_t   ld_be_i,
  input  core_mem_pkg::data_t ld_wdata_i,
  output logic                ld_gnt_o,
  output logic                ld_rvalid_o,
  output core_mem_pkg::data_t ld_rdata_o,

  // external bus for non-local accesses
  output logic                bus_req_o,
  output core_mem_pkg::addr_t bus_addr_o,
  output logic                bus_we_o,
  output core_mem_pkg::be_t   bus_be_o,
  output core_mem_pkg::data_t bus_wdata_o,
  input  logic                bus_gnt_i,
  input  logic                bus_rvalid_i,
  input  core_mem_pkg::data_t bus_rdata_i
);

  // demux to arbiter
  logic                    ram_req;
  logic                    ram_gnt;
  logic                    ram_rvalid;
  core_mem_pkg::addr_t     ram_addr;
  logic                    ram_we;
  core_mem_pkg::be_t       ram_be;
  core_mem_pkg::data_t     ram_wdata;
  core_mem_pkg::data_t     ram_rdata;

  // arbiter to data RAM
  logic                    mem_en;
  core_mem_pkg::ram_addr_t mem_addr;
  logic                    mem_we;
  core_mem_pkg::be_t       mem_be;
  core_mem_pkg::data_t     mem_wdata;
  core_mem_pkg::data_t     mem_rdata;

  lsu_demux u_lsu_demux
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),

    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),

    .bus_req_o    ( bus_req_o    ),
    .bus_addr_o   ( bus_addr_o   ),
    .bus_we_o     ( bus_we_o     ),
    .bus_be_o     ( bus_be_o     ),
    .bus_wdata_o  ( bus_wdata_o  ),
    .bus_gnt_i    ( bus_gnt_i    ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .bus_rdata_i  ( bus_rdata_i  ),

    .ram_req_o    ( ram_req      ),
    .ram_addr_o   ( ram_addr     ),
    .ram_we_o     ( ram_we       ),
    .ram_be_o     ( ram_be       ),
    .ram_wdata_o  ( ram_wdata    ),
    .ram_gnt_i    ( ram_gnt      ),
    .ram_rvalid_i ( ram_rvalid   ),
    .ram_rdata_i  ( ram_rdata    )
  );

  ram_arbiter u_ram_arbiter
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),

    .ld_req_i     ( ld_req_i     ),
    .ld_addr_i    ( ld_addr_i    ),
    .ld_we_i      ( ld_we_i      ),
    .ld_be_i      ( ld_be_i      ),
    .ld_wdata_i   ( ld_wdata_i   ),
    .ld_gnt_o     ( ld_gnt_o     ),
    .ld_rvalid_o  ( ld_rvalid_o  ),
    .ld_rdata_o   ( ld_rdata_o   ),

    .lsu_req_i    ( ram_req      ),
    .lsu_addr_i   ( ram_addr     ),
    .lsu_we_i     ( ram_we       ),
    .lsu_be_i     ( ram_be       ),
    .lsu_wdata_i  ( ram_wdata    ),
    .lsu_gnt_o    ( ram_gnt      ),
    .lsu_rvalid_o ( ram_rvalid   ),
    .lsu_rdata_o  ( ram_rdata    ),

    .mem_en_o     ( mem_en       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_we_o     ( mem_we       ),
    .mem_be_o     ( mem_be       ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_rdata_i  ( mem_rdata    )
  );

  sp_ram u_data_ram
  (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .addr_i  ( mem_addr  ),
    .we_i    ( mem_we    ),
    .be_i    ( mem_be    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

// File: sim/core_mem_assertions.sv
`include "core_mem_params.svh"

module core_mem_assertions
(
  input logic                clk,
  input logic                rst_n,
  input logic                ram_req,
  input logic                ram_gnt,
  input logic                ram_rvalid,
  input logic                ld_req_i,
  input logic                ld_gnt_o,
  input logic                ld_rvalid_o,
  input logic                bus_req_o,
  input core_mem_pkg::addr_t bus_addr_o,
  input logic                lsu_rvalid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // RAM answers exactly one cycle after the grant
  lsu_ram_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    ram_req && ram_gnt |=> ram_rvalid)
    else $error("lsu RAM access granted without rvalid one cycle later");

  ld_ram_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    ld_req_i && ld_gnt_o |=> ld_rvalid_o)
    else $error("loader access granted without rvalid one cycle later");

  bus_not_local: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o |-> bus_addr_o[`CMR_ADDR_WIDTH-1 -: `CMR_REGION_MSB_BITS] != `CMR_LOCAL_REGION)
    else $error("local address forwarded to the external bus");

  no_rvalid_in_reset: assert property (@(posedge clk) !rst_n |-> !lsu_rvalid_o)
    else $error("lsu rvalid high during reset");

endmodule

bind core_mem_region core_mem_assertions u_assertions
(
  .clk          ( clk          ),
  .rst_n        ( rst_n        ),
  .ram_req      ( ram_req      ),
  .ram_gnt      ( ram_gnt      ),
  .ram_rvalid   ( ram_rvalid   ),
  .ld_req_i     ( ld_req_i     ),
  .ld_gnt_o     ( ld_gnt_o     ),
  .ld_rvalid_o  ( ld_rvalid_o  ),
  .bus_req_o    ( bus_req_o    ),
  .bus_addr_o   ( bus_addr_o   ),
  .lsu_rvalid_o ( lsu_rvalid_o )
);

// File: sim/core_mem_region_tb.sv
`include "core_mem_params.svh"

module core_mem_region_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 50;
  // 11223344 with bytes 0 and 2 replaced by AABBCCDD
  localparam core_mem_pkg::data_t MERGED  = 32'h11BB_33DD;
  localparam core_mem_pkg::data_t LD_WORD = 32'hCAFE_F00D;
  localparam core_mem_pkg::data_t BUS_KEY = 32'hA5A5_A5A5;

  // port 0 is lsu, 1 is the loader
  typedef struct packed
  {
    logic                port;
    logic                we;
    core_mem_pkg::addr_t addr;
    core_mem_pkg::be_t   be;
    core_mem_pkg::data_t wdata;
    core_mem_pkg::data_t exp;
  } entry_t;

  logic clk;
  logic rst_n;
  logic lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  core_mem_pkg::addr_t lsu_addr_i;
  core_mem_pkg::be_t   lsu_be_i;
  core_mem_pkg::data_t lsu_wdata_i, lsu_rdata_o;
  logic ld_req_i, ld_we_i, ld_gnt_o, ld_rvalid_o;
  core_mem_pkg::addr_t ld_addr_i;
  core_mem_pkg::be_t   ld_be_i;
  core_mem_pkg::data_t ld_wdata_i, ld_rdata_o;
  logic bus_req_o, bus_we_o, bus_gnt_i, bus_rvalid_i;
  core_mem_pkg::addr_t bus_addr_o;
  core_mem_pkg::be_t   bus_be_o;
  core_mem_pkg::data_t bus_wdata_o, bus_rdata_i;

  // what the bus model saw at acceptance
  core_mem_pkg::addr_t bus_addr_seen;
  core_mem_pkg::be_t   bus_be_seen;
  core_mem_pkg::data_t bus_wdata_seen;
  logic                bus_we_seen;

  int     seed = 53578;
  int     errors = 0;
  int     checks = 0;
  int     n_entries = 0;
  entry_t stim [0:15];
  string  sig_names [4] = '{"lsu_gnt_o", "ld_gnt_o", "lsu_rvalid_o", "ld_rvalid_o"};

  core_mem_region DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // bus slave, random grant delay and response latency
  initial
  begin : bus_model
    int gnt_delay;
    int rsp_delay;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    forever
    begin
      @(negedge clk);
      #25;
      if (bus_req_o === 1'b1)
      begin
        gnt_delay = $unsigned($random(seed)) % 4;
        rsp_delay = $unsigned($random(seed)) % 4 + 1;
        repeat (gnt_delay + 1) @(negedge clk);
        bus_gnt_i = 1'b1;
        #25;
        bus_addr_seen  = bus_addr_o;
        bus_we_seen    = bus_we_o;
        bus_be_seen    = bus_be_o;
        bus_wdata_seen = bus_wdata_o;
        @(negedge clk);
        bus_gnt_i = 1'b0;
        repeat (rsp_delay - 1) @(negedge clk);
        bus_rvalid_i = 1'b1;
        bus_rdata_i  = bus_addr_seen ^ BUS_KEY;
        @(negedge clk);
        bus_rvalid_i = 1'b0;
      end
    end
  end

  task automatic check_data(input core_mem_pkg::data_t got, input core_mem_pkg::data_t exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input core_mem_pkg::addr_t got, input core_mem_pkg::addr_t exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_be(input core_mem_pkg::be_t got, input core_mem_pkg::be_t exp,
                          input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic sig_of(input int which);
    case (which)
      0: return lsu_gnt_o;
      1: return ld_gnt_o;
      2: return lsu_rvalid_o;
      default: return ld_rvalid_o;
    endcase
  endfunction

  // called on a falling edge, returns just before the rising edge where the signal is high
  task automatic wait_high(input int which, output int cycles);
    cycles = 0;
    #25;
    while (sig_of(which) !== 1'b1 && cycles < TIMEOUT)
    begin
      @(negedge clk);
      #25;
      cycles++;
    end
    if (sig_of(which) !== 1'b1)
    begin
      errors++;
      cycles = -1;
      $display("timeout at %0t ns: %s stayed low for %0d cycles", $time, sig_names[which],
               TIMEOUT);
    end
  endtask

  task automatic idle_inputs();
    lsu_req_i   = 1'b0;
    lsu_addr_i  = '0;
    lsu_we_i    = 1'b0;
    lsu_be_i    = '0;
    lsu_wdata_i = '0;
    ld_req_i    = 1'b0;
    ld_addr_i   = '0;
    ld_we_i     = 1'b0;
    ld_be_i     = '0;
    ld_wdata_i  = '0;
  endtask

  task automatic drive_req(input entry_t e, input logic req);
    if (e.port)
    begin
      ld_req_i   = req;
      ld_addr_i  = e.addr;
      ld_we_i    = e.we;
      ld_be_i    = e.be;
      ld_wdata_i = e.wdata;
    end
    else
    begin
      lsu_req_i   = req;
      lsu_addr_i  = e.addr;
      lsu_we_i    = e.we;
      lsu_be_i    = e.be;
      lsu_wdata_i = e.wdata;
    end
  endtask

  task automatic add_entry(input logic port, input logic we, input core_mem_pkg::addr_t addr,
                           input core_mem_pkg::be_t be, input core_mem_pkg::data_t wdata,
                           input core_mem_pkg::data_t exp);
    stim[n_entries] = {port, we, addr, be, wdata, exp};
    n_entries++;
  endtask

  task automatic run_entry(input entry_t e);
    int                  c;
    logic                local_hit;
    core_mem_pkg::data_t rdata;
    local_hit = (e.addr[`CMR_ADDR_WIDTH-1 -: `CMR_REGION_MSB_BITS] == `CMR_LOCAL_REGION);
    @(negedge clk);
    drive_req(e, 1'b1);
    wait_high(e.port, c);
    @(negedge clk);
    drive_req(e, 1'b0);
    if (c >= 0)
    begin
      wait_high(2 + e.port, c);
      rdata = e.port ? ld_rdata_o : lsu_rdata_o;
      if (c >= 0 && local_hit)
      begin
        check_flag(c == 0, 1'b1, "RAM rvalid one cycle after grant");
      end
      if (c >= 0 && !e.we)
      begin
        check_data(rdata, e.exp, "read data");
      end
      if (!local_hit)
      begin
        check_addr(bus_addr_seen, e.addr, "bus address");
        check_flag(bus_we_seen, e.we, "bus we");
        check_be(bus_be_seen, e.be, "bus be");
        check_data(bus_wdata_seen, e.wdata, "bus wdata");
      end
    end
  endtask

  // both peers in one cycle, loader first
  task automatic both_ports();
    @(negedge clk);
    ld_req_i   = 1'b1;
    ld_we_i    = 1'b0;
    ld_addr_i  = 32'h0010_0020;
    lsu_req_i  = 1'b1;
    lsu_we_i   = 1'b0;
    lsu_addr_i = 32'h0010_0010;
    #25;
    check_flag(ld_gnt_o, 1'b1, "ld grant on a shared cycle");
    check_flag(lsu_gnt_o, 1'b0, "lsu grant while ld requests");
    @(negedge clk);
    ld_req_i = 1'b0;
    #25;
    check_flag(ld_rvalid_o, 1'b1, "ld rvalid after its grant");
    check_flag(lsu_rvalid_o, 1'b0, "lsu rvalid before its grant");
    check_data(ld_rdata_o, LD_WORD, "ld read data");
    check_flag(lsu_gnt_o, 1'b1, "lsu grant after ld drops");
    @(negedge clk);
    lsu_req_i = 1'b0;
    #25;
    check_flag(lsu_rvalid_o, 1'b1, "lsu rvalid after its grant");
    check_data(lsu_rdata_o, MERGED, "lsu read data");
  endtask

  task automatic ordered_reads();
    int c;
    @(negedge clk);
    lsu_req_i  = 1'b1;
    lsu_we_i   = 1'b0;
    lsu_addr_i = 32'h0010_0010;
    #25;
    check_flag(lsu_gnt_o, 1'b1, "first back-to-back grant");
    @(negedge clk);
    lsu_addr_i = 32'h0010_0020;
    #25;
    check_flag(lsu_gnt_o, 1'b1, "second back-to-back grant");
    check_flag(lsu_rvalid_o, 1'b1, "first back-to-back rvalid");
    check_data(lsu_rdata_o, MERGED, "first back-to-back data");
    @(negedge clk);
    lsu_req_i = 1'b0;
    #25;
    check_flag(lsu_rvalid_o, 1'b1, "second back-to-back rvalid");
    check_data(lsu_rdata_o, LD_WORD, "second back-to-back data");
    // bus read, then a local read queued behind it
    @(negedge clk);
    lsu_req_i  = 1'b1;
    lsu_addr_i = 32'h4000_0200;
    wait_high(0, c);
    @(negedge clk);
    lsu_addr_i = 32'h0010_0020;
    wait_high(2, c);
    check_data(lsu_rdata_o, 32'h4000_0200 ^ BUS_KEY, "bus data ahead of local data");
    check_flag(lsu_gnt_o, 1'b0, "local grant while bus response pending");
    @(negedge clk);
    wait_high(0, c);
    @(negedge clk);
    lsu_req_i = 1'b0;
    #25;
    check_flag(lsu_rvalid_o, 1'b1, "local rvalid after bus response");
    check_data(lsu_rdata_o, LD_WORD, "local data after bus response");
  endtask

  initial
  begin
    rst_n = 1'b0;
    idle_inputs();
    add_entry(1'b0, 1'b1, 32'h0010_0010, 4'hF, 32'h1122_3344, '0);
    add_entry(1'b0, 1'b1, 32'h0010_0010, 4'h5, 32'hAABB_CCDD, '0);
    add_entry(1'b0, 1'b0, 32'h0010_0010, 4'hF, '0, MERGED);
    add_entry(1'b1, 1'b1, 32'h0010_0020, 4'hF, LD_WORD, '0);
    add_entry(1'b0, 1'b0, 32'h0010_0020, 4'hF, '0, LD_WORD);
    add_entry(1'b1, 1'b0, 32'h0010_0010, 4'hF, '0, MERGED);
    add_entry(1'b0, 1'b1, 32'h2000_0010, 4'h3, 32'h5A5A_1234, '0);
    add_entry(1'b0, 1'b0, 32'h4000_0124, 4'hF, '0, 32'h4000_0124 ^ BUS_KEY);
    add_entry(1'b0, 1'b0, 32'h0010_0010, 4'hF, '0, MERGED);
    // sixteen rising edges under reset
    repeat (16)
    begin
      @(posedge clk);
      #25;
      check_flag(lsu_rvalid_o | ld_rvalid_o | bus_req_o, 1'b0, "strobe during reset");
    end
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_entries; i++)
    begin
      run_entry(stim[i]);
    end
    both_ports();
    ordered_reads();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+design
design/core_mem_pkg.sv
design/sp_ram.sv
design/ram_arbiter.sv
design/lsu_demux.sv
design/core_mem_region.sv
sim/core_mem_assertions.sv
sim/core_mem_region_tb.sv
